/* hw/alu.sv */
`timescale 1ns/1ns

module alu import la32_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);

    logic [4:0] shamt;
    word_t      add_res;
    word_t      sub_res;
    word_t      slt_res;
    word_t      sltu_res;
    word_t      sll_res;
    word_t      srl_res;
    word_t      sra_res;

    assign shamt = src2[4:0];

    assign add_res  = src1 + src2;
    assign sub_res  = src1 - src2;
    assign slt_res  = {31'd0, $signed(src1) < $signed(src2)};
    assign sltu_res = {31'd0, src1 < src2};
    assign sll_res  = src1 << shamt;
    assign srl_res  = src1 >> shamt;
    assign sra_res  = $signed(src1) >>> shamt;

    // and-or mux, zero when no op is set
    assign result = ({32{alu_op[0]}}  & add_res)
                  | ({32{alu_op[1]}}  & sub_res)
                  | ({32{alu_op[2]}}  & slt_res)
                  | ({32{alu_op[3]}}  & sltu_res)
                  | ({32{alu_op[4]}}  & (src1 & src2))
                  | ({32{alu_op[5]}}  & ~(src1 | src2))
                  | ({32{alu_op[6]}}  & (src1 | src2))
                  | ({32{alu_op[7]}}  & (src1 ^ src2))
                  | ({32{alu_op[8]}}  & sll_res)
                  | ({32{alu_op[9]}}  & srl_res)
                  | ({32{alu_op[10]}} & sra_res)
                  | ({32{alu_op[11]}} & src2);  // lui, imm already shifted

endmodule

/* hw/decode_if.sv */
`timescale 1ns/1ns

interface decode_if import la32_pkg::*; ();

    alu_op_t  alu_op;
    word_t    imm;
    word_t    br_offs;
    word_t    jirl_offs;
    logic     src1_is_pc;
    logic     src2_is_imm;
    logic     src_reg_is_rd;  // second read port takes rd
    logic     res_from_mem;
    logic     gr_we;
    logic     mem_we;
    reg_idx_t dest;
    logic     is_b;
    logic     is_bl;
    logic     is_jirl;
    logic     is_beq;
    logic     is_bne;

    modport decoder (
        output alu_op, imm, br_offs, jirl_offs, src1_is_pc, src2_is_imm, src_reg_is_rd,
               res_from_mem, gr_we, mem_we, dest, is_b, is_bl, is_jirl, is_beq, is_bne
    );

    modport control (
        input  alu_op, imm, br_offs, jirl_offs, src1_is_pc, src2_is_imm, src_reg_is_rd,
               res_from_mem, gr_we, mem_we, dest, is_b, is_bl, is_jirl, is_beq, is_bne
    );

endinterface

/* hw/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder import la32_pkg::*; (
    input  word_t     inst,
    output reg_idx_t  raddr1,
    output reg_idx_t  raddr2,
    decode_if.decoder dec
);

    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_ld_w, inst_st_w, inst_lu12i_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};  // offs[25:16] sits low

    // ########################################
    // opcode match
    // ########################################
    assign inst_add_w   = inst[31:OP17_LSB] == OP17_ADD_W;
    assign inst_sub_w   = inst[31:OP17_LSB] == OP17_SUB_W;
    assign inst_slt     = inst[31:OP17_LSB] == OP17_SLT;
    assign inst_sltu    = inst[31:OP17_LSB] == OP17_SLTU;
    assign inst_nor     = inst[31:OP17_LSB] == OP17_NOR;
    assign inst_and     = inst[31:OP17_LSB] == OP17_AND;
    assign inst_or      = inst[31:OP17_LSB] == OP17_OR;
    assign inst_xor     = inst[31:OP17_LSB] == OP17_XOR;
    assign inst_slli_w  = inst[31:OP17_LSB] == OP17_SLLI_W;
    assign inst_srli_w  = inst[31:OP17_LSB] == OP17_SRLI_W;
    assign inst_srai_w  = inst[31:OP17_LSB] == OP17_SRAI_W;
    assign inst_addi_w  = inst[31:OP10_LSB] == OP10_ADDI_W;
    assign inst_ld_w    = inst[31:OP10_LSB] == OP10_LD_W;
    assign inst_st_w    = inst[31:OP10_LSB] == OP10_ST_W;
    assign inst_lu12i_w = inst[31:OP7_LSB] == OP7_LU12I_W;
    assign inst_jirl    = inst[31:OP6_LSB] == OP6_JIRL;
    assign inst_b       = inst[31:OP6_LSB] == OP6_B;
    assign inst_bl      = inst[31:OP6_LSB] == OP6_BL;
    assign inst_beq     = inst[31:OP6_LSB] == OP6_BEQ;
    assign inst_bne     = inst[31:OP6_LSB] == OP6_BNE;

    // ########################################
    // control bundle
    // ########################################
    assign dec.alu_op = {inst_lu12i_w, inst_srai_w, inst_srli_w, inst_slli_w,
                         inst_xor, inst_or, inst_nor, inst_and,
                         inst_sltu, inst_slt, inst_sub_w,
                         inst_add_w | inst_addi_w | inst_ld_w | inst_st_w | inst_jirl | inst_bl};

    // link value is pc + 4
    assign dec.imm = (inst_jirl | inst_bl) ? 32'd4 :
                     inst_lu12i_w          ? {i20, 12'b0} :
                                             {{20{i12[11]}}, i12};  // ui5 uses low bits only

    assign dec.br_offs   = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                                {{14{i16[15]}}, i16, 2'b0};
    assign dec.jirl_offs = {{14{i16[15]}}, i16, 2'b0};

    assign dec.src1_is_pc    = inst_jirl | inst_bl | inst_b;
    assign dec.src2_is_imm   = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w |
                               inst_ld_w | inst_st_w | inst_lu12i_w | inst_jirl | inst_bl;
    assign dec.src_reg_is_rd = inst_beq | inst_bne | inst_st_w;
    assign dec.res_from_mem  = inst_ld_w;
    assign dec.gr_we         = ~inst_st_w & ~inst_b & ~inst_beq & ~inst_bne;
    assign dec.mem_we        = inst_st_w;
    assign dec.dest          = inst_bl ? 5'd1 : rd;  // bl links through r1

    assign dec.is_b    = inst_b;
    assign dec.is_bl   = inst_bl;
    assign dec.is_jirl = inst_jirl;
    assign dec.is_beq  = inst_beq;
    assign dec.is_bne  = inst_bne;

    assign raddr1 = rj;
    assign raddr2 = dec.src_reg_is_rd ? rd : rk;

endmodule

/* hw/la32_pkg.sv */
package la32_pkg;

    // ########################################
    // basic types
    // ########################################

    typedef logic [31:0] word_t;     // data, address and instruction
    typedef logic [4:0]  reg_idx_t;  // general register number
    typedef logic [11:0] alu_op_t;   // one-hot, bit 0 is add

    typedef enum logic [2:0] {
        ST_IF,
        ST_ID,
        ST_EXE,
        ST_MEM,
        ST_WB
    } cpu_state_t;

    // ########################################
    // opcode fields
    // ########################################

    // low bit of each major opcode field, all fields end at bit 31
    localparam int OP17_LSB = 15;  // 3R and shift-imm forms
    localparam int OP10_LSB = 22;  // 2RI12 forms
    localparam int OP7_LSB  = 25;  // 1RI20 forms
    localparam int OP6_LSB  = 26;  // branch and jump forms

    localparam logic [16:0] OP17_ADD_W  = 17'h00020;
    localparam logic [16:0] OP17_SUB_W  = 17'h00022;
    localparam logic [16:0] OP17_SLT    = 17'h00024;
    localparam logic [16:0] OP17_SLTU   = 17'h00025;
    localparam logic [16:0] OP17_NOR    = 17'h00028;
    localparam logic [16:0] OP17_AND    = 17'h00029;
    localparam logic [16:0] OP17_OR     = 17'h0002a;
    localparam logic [16:0] OP17_XOR    = 17'h0002b;
    localparam logic [16:0] OP17_SLLI_W = 17'h00081;
    localparam logic [16:0] OP17_SRLI_W = 17'h00089;
    localparam logic [16:0] OP17_SRAI_W = 17'h00091;

    localparam logic [9:0]  OP10_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP10_LD_W   = 10'h0a2;
    localparam logic [9:0]  OP10_ST_W   = 10'h0a6;

    localparam logic [6:0]  OP7_LU12I_W = 7'h0a;

    localparam logic [5:0]  OP6_JIRL    = 6'h13;
    localparam logic [5:0]  OP6_B       = 6'h14;
    localparam logic [5:0]  OP6_BL      = 6'h15;
    localparam logic [5:0]  OP6_BEQ     = 6'h16;
    localparam logic [5:0]  OP6_BNE     = 6'h17;

endpackage

/* hw/mc_control.sv */
`timescale 1ns/1ns

module mc_control import la32_pkg::*; #(
    parameter word_t RESET_PC = 32'h1c00_0000
) (
    input  logic      clk,
    input  logic      reset,
    decode_if.control dec,
    input  word_t     inst_sram_rdata,
    input  word_t     data_sram_rdata,
    input  word_t     rdata1,
    input  word_t     rdata2,
    input  word_t     alu_result,
    output word_t     inst,
    output word_t     inst_sram_addr,
    output logic      data_sram_we,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    output word_t     alu_src1,
    output word_t     alu_src2,
    output logic      rf_we,
    output reg_idx_t  rf_waddr,
    output word_t     rf_wdata,
    output word_t     debug_wb_pc
);

    cpu_state_t state;
    cpu_state_t state_nxt;
    word_t      pc;
    word_t      seq_pc;
    word_t      br_target;
    word_t      store_data;
    word_t      alu_res_q;
    word_t      mem_res_q;
    logic       rj_eq_rd;
    logic       br_taken;

    // ########################################
    // state machine and pc
    // ########################################
    always_comb begin
        state_nxt = ST_IF;
        case (state)
            ST_IF:  state_nxt = ST_ID;
            ST_ID:  state_nxt = (dec.is_b | dec.is_beq | dec.is_bne) ? ST_IF : ST_EXE;
            ST_EXE: state_nxt = (dec.mem_we | dec.res_from_mem) ? ST_MEM : ST_WB;
            ST_MEM: state_nxt = dec.res_from_mem ? ST_WB : ST_IF;
            default: state_nxt = ST_IF;  // WB and anything odd
        endcase
    end

    assign seq_pc    = pc + 32'd4;
    assign rj_eq_rd  = rdata1 == rdata2;
    assign br_taken  = (dec.is_beq & rj_eq_rd) | (dec.is_bne & ~rj_eq_rd)
                     | dec.is_b | dec.is_bl | dec.is_jirl;
    assign br_target = dec.is_jirl ? rdata1 + dec.jirl_offs : pc + dec.br_offs;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IF;
            pc    <= RESET_PC;
        end else begin
            state <= state_nxt;
            if (state == ST_ID) begin
                pc <= br_taken ? br_target : seq_pc;  // resolved in decode
            end
        end
    end

    // ########################################
    // payload registers
    // ########################################
    always_ff @(posedge clk) begin
        case (state)
            ST_IF: inst <= inst_sram_rdata;
            ST_ID: begin
                debug_wb_pc <= pc;
                alu_src1    <= dec.src1_is_pc ? pc : rdata1;
                alu_src2    <= dec.src2_is_imm ? dec.imm : rdata2;
                store_data  <= rdata2;  // rd for st.w
            end
            ST_EXE: alu_res_q <= alu_result;
            ST_MEM: begin
                if (dec.res_from_mem) begin
                    mem_res_q <= data_sram_rdata;
                end
            end
            default: ;
        endcase
    end

    assign inst_sram_addr  = pc;
    assign data_sram_we    = (state == ST_MEM) && dec.mem_we;
    assign data_sram_addr  = alu_res_q;
    assign data_sram_wdata = store_data;
    assign rf_we           = (state == ST_WB) && dec.gr_we;
    assign rf_waddr        = dec.dest;
    assign rf_wdata        = dec.res_from_mem ? mem_res_q : alu_res_q;

    // ########################################
    // checks
    // ########################################
    a_state_legal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {ST_IF, ST_ID, ST_EXE, ST_MEM, ST_WB}
    ) else $error("illegal state %0d", state);

    a_store_in_mem: assert property (
        @(posedge clk) disable iff (reset)
        data_sram_we |-> state == ST_MEM && $past(state) == ST_EXE
    ) else $error("data write outside memory state");

    a_rf_we_in_wb: assert property (
        @(posedge clk) disable iff (reset)
        rf_we |-> state == ST_WB && $past(state) inside {ST_EXE, ST_MEM}
    ) else $error("register write outside writeback");

endmodule

/* hw/mycpu_top.sv */
`timescale 1ns/1ns

module mycpu_top import la32_pkg::*; #(
    parameter word_t RESET_PC = 32'h1c00_0000
) (
    input  logic     clk,
    input  logic     reset,
    // instruction sram
    output logic     inst_sram_we,
    output word_t    inst_sram_addr,
    output word_t    inst_sram_wdata,
    input  word_t    inst_sram_rdata,
    // data sram
    output logic     data_sram_we,
    output word_t    data_sram_addr,
    output word_t    data_sram_wdata,
    input  word_t    data_sram_rdata,
    // writeback trace
    output word_t    debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_idx_t debug_wb_rf_wnum,
    output word_t    debug_wb_rf_wdata
);

    word_t    inst;
    reg_idx_t raddr1;
    reg_idx_t raddr2;
    word_t    rdata1;
    word_t    rdata2;
    word_t    alu_src1;
    word_t    alu_src2;
    word_t    alu_result;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    decode_if dec_bus ();

    inst_decoder i_inst_decoder (
        .inst   (inst),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .dec    (dec_bus.decoder)
    );

    regfile i_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu i_alu (
        .alu_op (dec_bus.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    mc_control #(
        .RESET_PC (RESET_PC)
    ) i_mc_control (
        .clk             (clk),
        .reset           (reset),
        .dec             (dec_bus.control),
        .inst_sram_rdata (inst_sram_rdata),
        .data_sram_rdata (data_sram_rdata),
        .rdata1          (rdata1),
        .rdata2          (rdata2),
        .alu_result      (alu_result),
        .inst            (inst),
        .inst_sram_addr  (inst_sram_addr),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .alu_src1        (alu_src1),
        .alu_src2        (alu_src2),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .debug_wb_pc     (debug_wb_pc)
    );

    assign inst_sram_we      = 1'b0;  // instruction memory is read only
    assign inst_sram_wdata   = 32'd0;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ns

module regfile import la32_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin  // r0 stays zero
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

    // the write number comes from the decoder through the control unit
    a_waddr_known: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    ) else $error("register write with unknown address");

endmodule

/* project.f */
hw/la32_pkg.sv
hw/decode_if.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/alu.sv
hw/mc_control.sv
hw/mycpu_top.sv
verification/tb_sram_model.sv
verification/tb_mycpu_top.sv

/* verification/tb_mycpu_top.sv */
`timescale 1ns/1ns

module tb_mycpu_top import la32_pkg::*; ();

    localparam word_t RESET_PC   = 32'h1c00_0000;
    localparam word_t DATA_BASE  = 32'h1c01_0000;
    localparam int    SEED       = 47857;
    localparam int    PROG_LEN   = 38;
    localparam int    MAX_CYCLES = 2 * PROG_LEN * 5 + 20;  // twice the worst case

    logic       clk;
    logic       reset;
    logic       reset_q = 1'b0;
    logic       inst_sram_we;
    word_t      inst_sram_addr;
    word_t      inst_sram_wdata;
    word_t      inst_sram_rdata;
    logic       data_sram_we;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t      exp_pc [32];
    reg_idx_t   exp_num [32];
    word_t      exp_data [32];
    logic       exp_gap4 [32];  // next retirement follows 4 cycles later
    word_t      exp_st_addr [4];
    word_t      exp_st_data [4];
    int         n_retire = 0;
    int         n_store = 0;
    int         trace_idx = 0;
    int         store_idx = 0;
    int         cycle_cnt = 0;
    int         seed;
    word_t      rand_word;
    logic       retire;
    word_t      exp_pc_now;
    reg_idx_t   exp_num_now;
    word_t      exp_data_now;
    logic       exp_gap_now;
    word_t      exp_st_addr_now;
    word_t      exp_st_data_now;

    mycpu_top #(
        .RESET_PC (RESET_PC)
    ) i_mycpu_top (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_sram_model #(
        .RESET_PC  (RESET_PC),
        .DATA_BASE (DATA_BASE),
        .SEED      (SEED)
    ) i_sram_model (
        .clk             (clk),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .data_sram_rdata (data_sram_rdata)
    );

    task automatic add_retire(input word_t pc, input reg_idx_t num, input word_t data,
                              input logic gap4);
        exp_pc[n_retire]   = pc;
        exp_num[n_retire]  = num;
        exp_data[n_retire] = data;
        exp_gap4[n_retire] = gap4;
        n_retire++;
    endtask

    task automatic add_store(input word_t addr, input word_t data);
        exp_st_addr[n_store] = addr;
        exp_st_data[n_store] = data;
        n_store++;
    endtask

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        $display("FAIL %s expected %h got %h", name, expected, actual);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    // ########################################
    // expected retirements and stores
    // ########################################
    initial begin
        seed = SEED;
        for (int i = 0; i <= 16; i++) begin
            rand_word = $random(seed);  // ends on the word at ram index 16
        end
        add_retire(32'h1c00_0000, 5'd10, 32'h1c01_0000, 1'b1);
        add_retire(32'h1c00_0004, 5'd1,  32'h0000_0123, 1'b1);
        add_retire(32'h1c00_0008, 5'd2,  32'hffff_fdcb, 1'b1);
        add_retire(32'h1c00_000c, 5'd3,  32'hffff_feee, 1'b1);
        add_retire(32'h1c00_0010, 5'd4,  32'h0000_0358, 1'b1);
        add_retire(32'h1c00_0014, 5'd5,  32'h0000_0001, 1'b1);
        add_retire(32'h1c00_0018, 5'd6,  32'h0000_0000, 1'b1);
        add_retire(32'h1c00_001c, 5'd7,  32'h0000_0103, 1'b1);
        add_retire(32'h1c00_0020, 5'd8,  32'h0000_0214, 1'b1);
        add_retire(32'h1c00_0024, 5'd9,  32'hffff_fdeb, 1'b1);
        add_retire(32'h1c00_0028, 5'd11, 32'hffff_fce8, 1'b1);
        add_retire(32'h1c00_002c, 5'd12, 32'h0000_1230, 1'b1);
        add_retire(32'h1c00_0030, 5'd13, 32'h00ff_fffd, 1'b1);
        add_retire(32'h1c00_0034, 5'd14, 32'hffff_fffd, 1'b0);
        add_retire(32'h1c00_003c, 5'd15, 32'hffff_feee, 1'b0);
        add_retire(32'h1c00_0040, 5'd16, rand_word,     1'b0);
        add_retire(32'h1c00_0044, 5'd0,  32'h0000_05a5, 1'b1);  // r0 write still traced
        add_retire(32'h1c00_0048, 5'd17, 32'h0000_0123, 1'b0);
        add_retire(32'h1c00_0050, 5'd18, 32'h0000_0001, 1'b0);
        add_retire(32'h1c00_0060, 5'd20, 32'h0000_0002, 1'b0);
        add_retire(32'h1c00_0074, 5'd1,  32'h1c00_0078, 1'b0);  // bl link
        add_retire(32'h1c00_0080, 5'd22, 32'h1c00_0084, 1'b0);  // jirl link
        add_retire(32'h1c00_008c, 5'd23, 32'h0000_0002, 1'b0);
        add_retire(32'h1c00_0090, 5'd24, 32'h1c00_0084, 1'b0);
        add_store(32'h1c01_0010, 32'hffff_feee);
        add_store(32'h1c01_0020, 32'h0000_0002);
    end

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

    always @(posedge clk) begin
        reset_q   <= reset;
        cycle_cnt <= cycle_cnt + 1;
        if (!reset && retire) begin
            trace_idx <= trace_idx + 1;
        end
        if (!reset && data_sram_we) begin
            store_idx <= store_idx + 1;
        end
        if (cycle_cnt >= MAX_CYCLES) begin
            report_error("timeout: the program did not finish within the cycle limit");
        end
    end

    assign retire          = debug_wb_rf_we != 4'h0;
    assign exp_pc_now      = (trace_idx < n_retire) ? exp_pc[trace_idx] : '0;
    assign exp_num_now     = (trace_idx < n_retire) ? exp_num[trace_idx] : '0;
    assign exp_data_now    = (trace_idx < n_retire) ? exp_data[trace_idx] : '0;
    assign exp_gap_now     = (trace_idx < n_retire) ? exp_gap4[trace_idx] : 1'b0;
    assign exp_st_addr_now = (store_idx < n_store) ? exp_st_addr[store_idx] : '0;
    assign exp_st_data_now = (store_idx < n_store) ? exp_st_data[store_idx] : '0;

    // ########################################
    // checks
    // ########################################
    a_reset_rf_we: assert property (@(posedge clk) reset_q |-> debug_wb_rf_we == 4'h0)
        else report_mismatch("debug_wb_rf_we", 32'd0, $sampled(debug_wb_rf_we));
    a_reset_data_we: assert property (@(posedge clk) reset_q |-> !data_sram_we)
        else report_mismatch("data_sram_we", 32'd0, $sampled(data_sram_we));
    a_reset_pc: assert property (@(posedge clk) reset_q |-> inst_sram_addr == RESET_PC)
        else report_mismatch("inst_sram_addr", RESET_PC, $sampled(inst_sram_addr));
    a_inst_we_low: assert property (@(posedge clk) reset_q || !reset |-> !inst_sram_we)
        else report_mismatch("inst_sram_we", 32'd0, $sampled(inst_sram_we));
    a_inst_wdata_zero: assert property (
        @(posedge clk) reset_q || !reset |-> inst_sram_wdata == 32'd0
    ) else report_mismatch("inst_sram_wdata", 32'd0, $sampled(inst_sram_wdata));

    a_trace_pc: assert property (
        @(posedge clk) disable iff (reset) retire |-> debug_wb_pc == exp_pc_now
    ) else report_mismatch("debug_wb_pc", $sampled(exp_pc_now), $sampled(debug_wb_pc));
    a_trace_wnum: assert property (
        @(posedge clk) disable iff (reset) retire |-> debug_wb_rf_wnum == exp_num_now
    ) else report_mismatch("debug_wb_rf_wnum", $sampled(exp_num_now), $sampled(debug_wb_rf_wnum));
    a_trace_wdata: assert property (
        @(posedge clk) disable iff (reset) retire |-> debug_wb_rf_wdata == exp_data_now
    ) else report_mismatch("debug_wb_rf_wdata", $sampled(exp_data_now),
                           $sampled(debug_wb_rf_wdata));
    a_trace_gap: assert property (
        @(posedge clk) disable iff (reset)
        retire && exp_gap_now |=> (!retire) [*3] ##1 retire
    ) else report_error("back to back ALU instructions did not retire 4 cycles apart");

    a_store_addr: assert property (
        @(posedge clk) disable iff (reset) data_sram_we |-> data_sram_addr == exp_st_addr_now
    ) else report_mismatch("data_sram_addr", $sampled(exp_st_addr_now), $sampled(data_sram_addr));
    a_store_data: assert property (
        @(posedge clk) disable iff (reset) data_sram_we |-> data_sram_wdata == exp_st_data_now
    ) else report_mismatch("data_sram_wdata", $sampled(exp_st_data_now),
                           $sampled(data_sram_wdata));
    a_store_pulse: assert property (
        @(posedge clk) disable iff (reset) data_sram_we |=> !data_sram_we
    ) else report_error("data_sram_we stayed high for more than one cycle");

    initial begin
        wait (n_retire > 0 && trace_idx == n_retire);
        @(posedge clk);
        if (store_idx == n_store) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_error("all registers retired but not every expected store was seen");
        end
    end

endmodule

/* verification/tb_sram_model.sv */
`timescale 1ns/1ns

module tb_sram_model import la32_pkg::*; #(
    parameter word_t RESET_PC  = 32'h1c00_0000,
    parameter word_t DATA_BASE = 32'h1c01_0000,
    parameter int    SEED      = 1
) (
    input  logic  clk,
    input  word_t inst_sram_addr,
    output word_t inst_sram_rdata,
    input  logic  data_sram_we,
    input  word_t data_sram_addr,
    input  word_t data_sram_wdata,
    output word_t data_sram_rdata
);

    localparam int PROG_LEN = 38;

    word_t rom [PROG_LEN];
    word_t ram [256];
    word_t rom_offs;
    logic  ram_hit;
    int    seed;
    int    i;

    initial begin
        seed = SEED;
        for (i = 0; i < 256; i++) begin
            ram[i] = $random(seed);
        end
        // ########################################
        // alu and lu12i.w
        // ########################################
        rom[0]  = 32'h1438020a;  // lu12i.w r10, 0x1c010
        rom[1]  = 32'h02848c01;  // addi.w  r1, r0, 0x123
        rom[2]  = 32'h02b72c02;  // addi.w  r2, r0, -0x235
        rom[3]  = 32'h00100823;  // add.w   r3, r1, r2
        rom[4]  = 32'h00110824;  // sub.w   r4, r1, r2
        rom[5]  = 32'h00120445;  // slt     r5, r2, r1
        rom[6]  = 32'h00128446;  // sltu    r6, r2, r1
        rom[7]  = 32'h00148827;  // and     r7, r1, r2
        rom[8]  = 32'h00140828;  // nor     r8, r1, r2
        rom[9]  = 32'h00150829;  // or      r9, r1, r2
        rom[10] = 32'h0015882b;  // xor     r11, r1, r2
        rom[11] = 32'h0040902c;  // slli.w  r12, r1, 4
        rom[12] = 32'h0044a04d;  // srli.w  r13, r2, 8
        rom[13] = 32'h0048a04e;  // srai.w  r14, r2, 8
        // ########################################
        // memory, r0 and branches
        // ########################################
        rom[14] = 32'h29804143;  // st.w    r3, r10, 0x10
        rom[15] = 32'h2880414f;  // ld.w    r15, r10, 0x10
        rom[16] = 32'h28810150;  // ld.w    r16, r10, 0x40, untouched word
        rom[17] = 32'h02969400;  // addi.w  r0, r0, 0x5a5
        rom[18] = 32'h00100411;  // add.w   r17, r0, r1
        rom[19] = 32'h58000823;  // beq     r1, r3, +8, not taken
        rom[20] = 32'h02800412;  // addi.w  r18, r0, 1
        rom[21] = 32'h58000831;  // beq     r1, r17, +8, taken
        rom[22] = 32'h02999813;  // addi.w  r19, r0, 0x666, skipped
        rom[23] = 32'h5c000831;  // bne     r1, r17, +8, not taken
        rom[24] = 32'h02800814;  // addi.w  r20, r0, 2
        rom[25] = 32'h5c000823;  // bne     r1, r3, +8, taken
        rom[26] = 32'h029ddc13;  // addi.w  r19, r0, 0x777, skipped
        rom[27] = 32'h50000800;  // b       +8
        rom[28] = 32'h02844413;  // addi.w  r19, r0, 0x111, skipped
        rom[29] = 32'h54000c00;  // bl      +12
        rom[30] = 32'h02800c15;  // addi.w  r21, r0, 3, skipped
        rom[31] = 32'h02801015;  // addi.w  r21, r0, 4, skipped
        rom[32] = 32'h4c001036;  // jirl    r22, r1, 16
        rom[33] = 32'h02801415;  // addi.w  r21, r0, 5, skipped
        rom[34] = 32'h29808154;  // st.w    r20, r10, 0x20
        rom[35] = 32'h28808157;  // ld.w    r23, r10, 0x20
        rom[36] = 32'h001002d8;  // add.w   r24, r22, r0
        rom[37] = 32'h50000000;  // b       0, parks the core
    end

    assign rom_offs        = inst_sram_addr - RESET_PC;
    assign inst_sram_rdata = (rom_offs < 4 * PROG_LEN) ? rom[rom_offs[31:2]] : ~inst_sram_addr;

    assign ram_hit         = data_sram_addr[31:10] == DATA_BASE[31:10];
    assign data_sram_rdata = ram_hit ? ram[data_sram_addr[9:2]] : ~data_sram_addr;

    always @(posedge clk) begin
        if (data_sram_we && ram_hit) begin
            ram[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

endmodule
